// File: core_pkg.sv
// Shared types and constants for the RV32 load/ADDI core slice.
// Every RTL file and the testbench import this package by wildcard.
// Holds the vector typedefs, opcode and funct3 codes, the arbiter state
// and the structs passed between pipeline stages.

package core_pkg;

    // ========================================================================
    // widths with a meaning
    // ========================================================================
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  axi_size_t;

    localparam addr_t pc_reset = 32'h0000_0000;
    // ADDI x0, x0, 0
    localparam word_t nop_word = 32'h0000_0013;

    localparam logic [6:0] opc_load   = 7'b000_0011;
    localparam logic [6:0] opc_op_imm = 7'b001_0011;

    localparam logic [2:0] f3_lb   = 3'b000;
    localparam logic [2:0] f3_lh   = 3'b001;
    localparam logic [2:0] f3_lw   = 3'b010;
    localparam logic [2:0] f3_lbu  = 3'b100;
    localparam logic [2:0] f3_lhu  = 3'b101;
    localparam logic [2:0] f3_addi = 3'b000;

    localparam logic [1:0] resp_okay = 2'b00;
    localparam logic [3:0] arb_id    = 4'h0;

    typedef enum logic [1:0] {
        arb_idle,
        arb_addr,
        arb_wait,
        arb_done
    } arb_state_e;

    // ========================================================================
    // stage payloads
    // ========================================================================
    typedef struct packed {
        addr_t     addr;
        axi_size_t size;
    } read_req_t;

    typedef struct packed {
        word_t data;
        logic  err;
    } read_rsp_t;

    typedef struct packed {
        addr_t      pc;
        logic       is_load;
        logic       illegal;
        logic [2:0] funct3;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        word_t      imm;
    } decoded_op_t;

    // value is the ADDI sum, or the raw load word before alignment
    typedef struct packed {
        addr_t      pc;
        reg_idx_t   rd;
        word_t      value;
        logic       is_load;
        logic [2:0] funct3;
        logic [1:0] byte_off;
        logic       err;
    } result_t;

    typedef struct packed {
        addr_t    pc;
        reg_idx_t rd;
        word_t    value;
        logic     we;
    } retire_t;

endpackage

// File: read_arbiter.sv
// Shares one single-beat AXI read master between instruction fetch and
// load data. The load side wins when both request in the same cycle.
// Picks the 32-bit lane of the 64-bit read data by address bit 2 and
// flags bad response codes or IDs on load responses.

`timescale 1ns/1ps

module read_arbiter
    import core_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // fetch side
    input  addr_t       ifetch_addr,
    input  logic        ifetch_valid,
    output logic        ifetch_ready,
    output word_t       ifetch_data,
    output logic        ifetch_data_valid,
    input  logic        ifetch_data_ready,
    // load side
    input  read_req_t   load_req,
    input  logic        load_req_valid,
    output logic        load_req_ready,
    output read_rsp_t   load_rsp,
    output logic        load_rsp_valid,
    input  logic        load_rsp_ready,
    // AXI read channels
    output logic        arvalid,
    input  logic        arready,
    output addr_t       araddr,
    output axi_size_t   arsize,
    output logic [3:0]  arid,
    output logic [7:0]  arlen,
    output logic [1:0]  arburst,
    input  logic        rvalid,
    output logic        rready,
    input  logic [1:0]  rresp,
    input  logic [63:0] rdata,
    input  logic        rlast,
    input  logic [3:0]  rid
);

    arb_state_e state;
    logic       grant_load;
    word_t      rsp_data;
    logic       rsp_err;
    logic       ifetch_take;
    logic       load_take;
    logic       rsp_take;
    logic       last_beat;

    // data side only needs an idle arbiter, fetch also yields to it
    assign load_req_ready = (state == arb_idle);
    assign ifetch_ready   = (state == arb_idle) && !load_req_valid;

    assign ifetch_take = ifetch_valid && ifetch_ready;
    assign load_take   = load_req_valid && load_req_ready;
    assign last_beat   = rvalid && rready && rlast;

    assign ifetch_data_valid = (state == arb_done) && !grant_load;
    assign load_rsp_valid    = (state == arb_done) && grant_load;
    assign ifetch_data       = rsp_data;
    assign load_rsp          = '{data: rsp_data, err: rsp_err};
    assign rsp_take          = grant_load ? load_rsp_ready : ifetch_data_ready;

    assign arvalid = (state == arb_addr);
    assign rready  = (state == arb_wait);
    assign arid    = arb_id;
    assign arlen   = 8'd0;
    // FIXED burst
    assign arburst = 2'b00;

    // ========================================================================
    // state machine
    // ========================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= arb_idle;
            grant_load <= 1'b0;
        end else begin
            case (state)
                arb_idle: begin
                    if (load_take || ifetch_take) begin
                        state      <= arb_addr;
                        grant_load <= load_take;
                    end
                end
                arb_addr: if (arready) state <= arb_wait;
                arb_wait: if (last_beat) state <= arb_done;
                arb_done: if (rsp_take) state <= arb_idle;
                default:  state <= arb_idle;
            endcase
        end
    end

    // request capture, fetches are always full words
    always_ff @(posedge clk) begin
        if (load_take) begin
            araddr <= load_req.addr;
            arsize <= load_req.size;
        end else if (ifetch_take) begin
            araddr <= ifetch_addr;
            arsize <= 3'd2;
        end
    end

    // lane select and response check on the final beat
    always_ff @(posedge clk) begin
        if (last_beat) begin
            rsp_data <= araddr[2] ? rdata[63:32] : rdata[31:0];
            rsp_err  <= (rresp != resp_okay) || (rid != arb_id);
        end
    end

endmodule

// File: fetch_unit.sv
// Instruction fetch. Holds the pc and keeps one fetched word for decode.
// A new fetch goes out as soon as the buffer is empty, so the next word
// can arrive while an older load is still waiting on the bus.

`timescale 1ns/1ps

module fetch_unit
    import core_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    output addr_t ifetch_addr,
    output logic  ifetch_valid,
    input  logic  ifetch_ready,
    input  word_t ifetch_data,
    input  logic  ifetch_data_valid,
    output logic  ifetch_data_ready,
    output word_t inst_word,
    output addr_t inst_pc,
    output logic  inst_valid,
    input  logic  inst_ready
);

    addr_t pc;
    logic  pending;
    logic  buf_valid;

    // one request in flight, and never while the buffer is occupied
    assign ifetch_addr       = pc;
    assign ifetch_valid      = !pending && !buf_valid;
    assign ifetch_data_ready = !buf_valid;
    assign inst_valid        = buf_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= pc_reset;
            pending   <= 1'b0;
            buf_valid <= 1'b0;
        end else begin
            if (ifetch_valid && ifetch_ready) begin
                pc      <= pc + 32'd4;
                pending <= 1'b1;
            end
            if (ifetch_data_valid && ifetch_data_ready) begin
                pending   <= 1'b0;
                buf_valid <= 1'b1;
            end else if (inst_valid && inst_ready) begin
                buf_valid <= 1'b0;
            end
        end
    end

    // pc already moved past the word in flight
    always_ff @(posedge clk) begin
        if (ifetch_data_valid && ifetch_data_ready) begin
            inst_word <= ifetch_data;
            inst_pc   <= pc - 32'd4;
        end
    end

endmodule

// File: inst_decode.sv
// Decode stage. Turns an instruction word into a registered decoded op.
// Only ADDI and the five loads are legal; anything else is marked illegal
// and decoded as a NOP so it retires without writing a register.

`timescale 1ns/1ps

module inst_decode
    import core_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  word_t       inst_word,
    input  addr_t       inst_pc,
    input  logic        inst_valid,
    output logic        inst_ready,
    output decoded_op_t op,
    output logic        op_valid,
    input  logic        op_ready
);

    decoded_op_t dec;
    word_t       word;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic        is_addi;
    logic        is_load;

    assign opcode = inst_word[6:0];
    assign funct3 = inst_word[14:12];

    assign is_addi = (opcode == opc_op_imm) && (funct3 == f3_addi);
    assign is_load = (opcode == opc_load) &&
                     ((funct3 == f3_lb)  || (funct3 == f3_lh) || (funct3 == f3_lw) ||
                      (funct3 == f3_lbu) || (funct3 == f3_lhu));

    // illegal words become ADDI x0, x0, 0
    assign word = (is_addi || is_load) ? inst_word : nop_word;

    always_comb begin
        dec.pc      = inst_pc;
        dec.is_load = is_load;
        dec.illegal = !(is_addi || is_load);
        dec.funct3  = word[14:12];
        dec.rd      = word[11:7];
        dec.rs1     = word[19:15];
        dec.imm     = {{20{word[31]}}, word[31:20]};
    end

    // take a word when the output register is free or draining
    assign inst_ready = !op_valid || op_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            op_valid <= 1'b0;
        end else if (inst_valid && inst_ready) begin
            op_valid <= 1'b1;
        end else if (op_ready) begin
            op_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid && inst_ready) begin
            op <= dec;
        end
    end

endmodule

// File: load_execute.sv
// Execute stage. Adds rs1 and the immediate: that sum is the ADDI result
// or the load address. Loads go out through the arbiter and the raw word
// comes back into the result, which writeback aligns and extends.

`timescale 1ns/1ps

module load_execute
    import core_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  decoded_op_t op,
    input  logic        op_valid,
    output logic        op_ready,
    output reg_idx_t    rs1_idx,
    input  word_t       rs1_data,
    output read_req_t   load_req,
    output logic        load_req_valid,
    input  logic        load_req_ready,
    input  read_rsp_t   load_rsp,
    input  logic        load_rsp_valid,
    output logic        load_rsp_ready,
    output result_t     res,
    output logic        res_valid,
    input  logic        res_ready
);

    typedef enum logic [1:0] {
        ex_idle,
        ex_req,
        ex_wait,
        ex_res
    } ex_state_e;

    ex_state_e state;
    word_t     sum;
    logic      take_op;

    assign rs1_idx = op.rs1;
    assign sum     = rs1_data + op.imm;
    assign take_op = op_valid && op_ready;

    assign op_ready       = (state == ex_idle);
    assign load_req_valid = (state == ex_req);
    assign load_rsp_ready = (state == ex_wait);
    assign res_valid      = (state == ex_res);

    // res.value holds the address until the load data replaces it
    assign load_req = '{addr: res.value, size: {1'b0, res.funct3[1:0]}};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ex_idle;
        end else begin
            case (state)
                ex_idle: if (take_op) state <= op.is_load ? ex_req : ex_res;
                ex_req:  if (load_req_ready) state <= ex_wait;
                ex_wait: if (load_rsp_valid) state <= ex_res;
                ex_res:  if (res_ready) state <= ex_idle;
                default: state <= ex_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take_op) begin
            res.pc       <= op.pc;
            res.rd       <= op.rd;
            res.value    <= sum;
            res.is_load  <= op.is_load;
            res.funct3   <= op.funct3;
            res.byte_off <= sum[1:0];
            res.err      <= 1'b0;
        end else if (load_rsp_valid && load_rsp_ready) begin
            res.value <= load_rsp.data;
            res.err   <= load_rsp.err;
        end
    end

endmodule

// File: result_writeback.sv
// Writeback stage with the 32-entry register file. Aligns load data by
// byte offset and extends it by funct3, writes rd and emits one retire
// record per result. The pending write is forwarded to the rs1 read.

`timescale 1ns/1ps

module result_writeback
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  result_t  res,
    input  logic     res_valid,
    output logic     res_ready,
    input  reg_idx_t rs1_idx,
    output word_t    rs1_data,
    output retire_t  retire,
    output logic     retire_valid,
    output logic     bus_error
);

    word_t rf [32];
    word_t shifted;
    word_t load_val;
    logic  take_res;

    // busy only in the cycle the register file is written
    assign res_ready = !retire_valid;
    assign take_res  = res_valid && res_ready;

    assign shifted = res.value >> {res.byte_off, 3'b000};

    always_comb begin
        case (res.funct3)
            f3_lb:   load_val = {{24{shifted[7]}}, shifted[7:0]};
            f3_lh:   load_val = {{16{shifted[15]}}, shifted[15:0]};
            f3_lbu:  load_val = {24'd0, shifted[7:0]};
            f3_lhu:  load_val = {16'd0, shifted[15:0]};
            default: load_val = shifted;
        endcase
    end

    // x0 reads zero, the write in progress overrides the array
    always_comb begin
        if (rs1_idx == 5'd0) begin
            rs1_data = '0;
        end else if (retire_valid && retire.we && (retire.rd == rs1_idx)) begin
            rs1_data = retire.value;
        end else begin
            rs1_data = rf[rs1_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
            bus_error    <= 1'b0;
        end else begin
            retire_valid <= take_res;
            if (take_res && res.is_load && res.err) begin
                bus_error <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_res) begin
            retire.pc    <= res.pc;
            retire.rd    <= res.rd;
            retire.value <= res.is_load ? load_val : res.value;
            retire.we    <= (res.rd != 5'd0);
        end
    end

    always_ff @(posedge clk) begin
        if (retire_valid && retire.we) begin
            rf[retire.rd] <= retire.value;
        end
    end

endmodule

// File: mini_core_top.sv
// Top level of the core slice: fetch, decode, execute and writeback
// around one shared AXI read port. Instance ports connect by name to the
// nets below. Also keeps the sticky illegal instruction flag.

`timescale 1ns/1ps

module mini_core_top
    import core_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // AXI read master
    output logic        arvalid,
    input  logic        arready,
    output addr_t       araddr,
    output axi_size_t   arsize,
    output logic [3:0]  arid,
    output logic [7:0]  arlen,
    output logic [1:0]  arburst,
    input  logic        rvalid,
    output logic        rready,
    input  logic [1:0]  rresp,
    input  logic [63:0] rdata,
    input  logic        rlast,
    input  logic [3:0]  rid,
    // retirement and status
    output retire_t     retire,
    output logic        retire_valid,
    output logic        illegal_inst,
    output logic        bus_error
);

    // ========================================================================
    // stage to stage nets
    // ========================================================================
    addr_t       ifetch_addr;
    logic        ifetch_valid;
    logic        ifetch_ready;
    word_t       ifetch_data;
    logic        ifetch_data_valid;
    logic        ifetch_data_ready;

    word_t       inst_word;
    addr_t       inst_pc;
    logic        inst_valid;
    logic        inst_ready;

    decoded_op_t op;
    logic        op_valid;
    logic        op_ready;

    reg_idx_t    rs1_idx;
    word_t       rs1_data;
    read_req_t   load_req;
    logic        load_req_valid;
    logic        load_req_ready;
    read_rsp_t   load_rsp;
    logic        load_rsp_valid;
    logic        load_rsp_ready;

    result_t     res;
    logic        res_valid;
    logic        res_ready;

    fetch_unit       fetch_i  (.*);
    inst_decode      decode_i (.*);
    load_execute     exec_i   (.*);
    result_writeback wb_i     (.*);
    read_arbiter     arb_i    (.*);

    // set once execute accepts an illegal op
    always_ff @(posedge clk) begin
        if (rst) begin
            illegal_inst <= 1'b0;
        end else if (op_valid && op_ready && op.illegal) begin
            illegal_inst <= 1'b1;
        end
    end

endmodule

// File: core_sva.sv
// Read port protocol checks, bound into every read_arbiter instance.
// Covers data-side priority, AR stability and fields, and R ordering.

`timescale 1ns/1ps

module core_sva
    import core_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       arvalid,
    input logic       arready,
    input addr_t      araddr,
    input axi_size_t  arsize,
    input logic [3:0] arid,
    input logic [7:0] arlen,
    input logic [1:0] arburst,
    input logic       rvalid,
    input logic       rready,
    input logic       rlast,
    input logic       load_req_valid,
    input logic       ifetch_ready
);

    int   fail_count = 0;
    logic addr_done;

    // set between the AR handshake and the last R beat
    always_ff @(posedge clk) begin
        if (rst) begin
            addr_done <= 1'b0;
        end else if (arvalid && arready) begin
            addr_done <= 1'b1;
        end else if (rvalid && rready && rlast) begin
            addr_done <= 1'b0;
        end
    end

    a_load_first: assert property (@(posedge clk) disable iff (rst)
        load_req_valid |-> !ifetch_ready)
    else begin
        $error("fetch side ready while a load request is waiting");
        fail_count++;
    end

    a_ar_stable: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arsize))
    else begin
        $error("read address dropped or changed before arready");
        fail_count++;
    end

    // FIXED bursts only
    a_ar_fields: assert property (@(posedge clk) disable iff (rst)
        arvalid |-> (arlen == 8'd0) && (arid == arb_id) && (arburst == 2'b00))
    else begin
        $error("read address with a nonzero length or id, or a burst type other than FIXED");
        fail_count++;
    end

    a_rready_order: assert property (@(posedge clk) disable iff (rst)
        rready |-> addr_done)
    else begin
        $error("rready raised before the address transfer");
        fail_count++;
    end

endmodule

bind read_arbiter core_sva sva_i (.*);

// File: tb_top.sv
// Testbench for mini_core_top. Loads a small program and a data table
// into an AXI read memory model, runs a reference model over the same
// image and checks each retirement against it with concurrent assertions.
// Ends with one count line and the result line.

`timescale 1ns/1ps

module tb_top
    import core_pkg::*;
();

    // about 60 instructions at under 30 cycles each, plus reset
    localparam int    cycle_limit = 2000;
    localparam addr_t data_base   = 32'h0000_0200;
    localparam addr_t err_addr    = 32'h0000_0300;

    logic        clk     = 1'b0;
    logic        rst     = 1'b1;
    logic        arvalid;
    logic        arready = 1'b0;
    addr_t       araddr;
    axi_size_t   arsize;
    logic [3:0]  arid;
    logic [7:0]  arlen;
    logic [1:0]  arburst;
    logic        rvalid  = 1'b0;
    logic        rready;
    logic [1:0]  rresp   = 2'b00;
    logic [63:0] rdata   = '0;
    logic        rlast   = 1'b0;
    logic [3:0]  rid     = 4'h0;
    retire_t     retire;
    logic        retire_valid;
    logic        illegal_inst;
    logic        bus_error;

    word_t   mem [256];
    int      prog_len;
    int      prog_end;
    addr_t   illegal_pc;
    addr_t   err_pc;
    retire_t exp_q [$];
    retire_t exp_head;
    int      exp_total      = 0;
    int      retired        = 0;
    int      cycles         = 0;
    int      mismatch_count = 0;
    int      error_count    = 0;
    int      sva_fails;
    logic    checking;

    // expected load sizes in program order
    axi_size_t size_q [$];
    axi_size_t size_head;
    int      loads_seen     = 0;
    logic    load_ar;

    // memory model state
    int      ar_delay;
    int      r_delay;
    logic    r_busy;
    addr_t   r_addr;

    mini_core_top dut_i (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    // ========================================================================
    // program image and reference model
    // ========================================================================
    function automatic word_t addi_word(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
        return {imm, rs1, f3_addi, rd, opc_op_imm};
    endfunction

    function automatic word_t load_word(logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1,
                                        logic [11:0] imm);
        return {imm, rs1, f3, rd, opc_load};
    endfunction

    task automatic put_inst(input word_t w);
        mem[prog_len] = w;
        prog_len++;
    endtask

    task automatic fill_memory();
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'hc0de_0000 | (i << 2);
        end
        // mixed sign bits in bytes and halves
        mem[data_base[9:2]]     = 32'h8a7f_f501;
        mem[data_base[9:2] + 1] = 32'h6b80_1c93;
    endtask

    task automatic build_program();
        prog_len = 0;
        put_inst(addi_word(5'd1, 5'd0, data_base[11:0]));
        // dependent chain over x2..x11
        for (int i = 0; i < 20; i++) begin
            put_inst(addi_word(5'(2 + i % 10), (i == 0) ? 5'd1 : 5'(2 + (i - 1) % 10),
                               12'(i * 73 - 700)));
        end
        put_inst(addi_word(5'd0, 5'd4, 12'd99));
        put_inst(addi_word(5'd12, 5'd0, 12'hfff));
        put_inst(addi_word(5'd13, 5'd12, 12'h7ff));
        // every width at every legal offset, in both lanes
        for (int w = 0; w < 8; w += 4) begin
            for (int off = 0; off < 4; off++) begin
                put_inst(load_word(f3_lb, 5'(14 + prog_len % 6), 5'd1, 12'(w + off)));
                put_inst(load_word(f3_lbu, 5'(14 + prog_len % 6), 5'd1, 12'(w + off)));
            end
            for (int off = 0; off < 4; off += 2) begin
                put_inst(load_word(f3_lh, 5'(14 + prog_len % 6), 5'd1, 12'(w + off)));
                put_inst(load_word(f3_lhu, 5'(14 + prog_len % 6), 5'd1, 12'(w + off)));
            end
            put_inst(load_word(f3_lw, 5'(14 + prog_len % 6), 5'd1, 12'(w)));
        end
        put_inst(addi_word(5'd20, 5'(14 + (prog_len - 1) % 6), 12'd1));
        put_inst(load_word(f3_lw, 5'd0, 5'd1, 12'd0));
        illegal_pc = addr_t'(prog_len * 4);
        // add x1, x1, x2
        put_inst(32'h0020_80b3);
        err_pc = addr_t'(prog_len * 4);
        put_inst(load_word(f3_lw, 5'd21, 5'd1, 12'(err_addr - data_base)));
        prog_end = prog_len;
        for (int i = 0; i < 8; i++) begin
            put_inst(nop_word);
        end
    endtask

    task automatic run_reference();
        word_t      regs [32];
        word_t      w;
        word_t      imm;
        word_t      a;
        word_t      lw;
        word_t      val;
        logic [6:0] opc;
        logic [2:0] f3;
        reg_idx_t   rd;
        retire_t    rec;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < prog_end; i++) begin
            w   = mem[i];
            opc = w[6:0];
            f3  = w[14:12];
            rd  = w[11:7];
            imm = {{20{w[31]}}, w[31:20]};
            a   = regs[w[19:15]] + imm;
            val = a;
            if ((opc == opc_load) && (f3 inside {f3_lb, f3_lh, f3_lw, f3_lbu, f3_lhu})) begin
                lw = mem[a[9:2]] >> (8 * a[1:0]);
                case (f3)
                    f3_lb:   val = {{24{lw[7]}}, lw[7:0]};
                    f3_lh:   val = {{16{lw[15]}}, lw[15:0]};
                    f3_lbu:  val = {24'd0, lw[7:0]};
                    f3_lhu:  val = {16'd0, lw[15:0]};
                    default: val = lw;
                endcase
                size_q.push_back((f3 == f3_lw) ? 3'd2 :
                                 ((f3 == f3_lh) || (f3 == f3_lhu)) ? 3'd1 : 3'd0);
            end else if (!((opc == opc_op_imm) && (f3 == f3_addi))) begin
                rd  = 5'd0;
                val = '0;
            end
            if (rd != 5'd0) begin
                regs[rd] = val;
            end
            rec.pc    = addr_t'(i * 4);
            rec.rd    = rd;
            rec.value = val;
            rec.we    = (rd != 5'd0);
            exp_q.push_back(rec);
        end
    endtask

    // ========================================================================
    // AXI read memory model
    // ========================================================================
    always @(posedge clk) begin
        if (rst) begin
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            rlast    <= 1'b0;
            r_busy   <= 1'b0;
            ar_delay <= $urandom_range(3);
        end else begin
            arready <= 1'b0;
            if (arvalid && arready) begin
                r_addr   <= araddr;
                r_busy   <= 1'b1;
                r_delay  <= $urandom_range(3);
                ar_delay <= $urandom_range(3);
            end else if (arvalid) begin
                if (ar_delay == 0) begin
                    arready <= 1'b1;
                end else begin
                    ar_delay <= ar_delay - 1;
                end
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                rlast  <= 1'b0;
                r_busy <= 1'b0;
            end else if (r_busy && !rvalid) begin
                if (r_delay == 0) begin
                    rvalid <= 1'b1;
                    rlast  <= 1'b1;
                    rid    <= arb_id;
                    // addressed word lands in the lane picked by bit 2
                    rdata  <= {mem[{r_addr[9:3], 1'b1}], mem[{r_addr[9:3], 1'b0}]};
                    rresp  <= (r_addr[31:2] == err_addr[31:2]) ? 2'b10 : resp_okay;
                end else begin
                    r_delay <= r_delay - 1;
                end
            end
        end
    end

    // ========================================================================
    // retirement checks
    // ========================================================================
    assign checking = retire_valid && (retired < exp_total);

    always @(posedge clk) begin
        if (checking) begin
            retired <= retired + 1;
            if (retired + 1 < exp_total) begin
                exp_head <= exp_q[retired + 1];
            end
        end
    end

    a_retire_pc: assert property (@(posedge clk) disable iff (rst)
        checking |-> retire.pc == exp_head.pc)
    else begin
        $display("MISMATCH time=%0t retire.pc got=%h expected=%h",
                 $time, $sampled(retire.pc), $sampled(exp_head.pc));
        mismatch_count++;
    end

    a_retire_rd: assert property (@(posedge clk) disable iff (rst)
        checking |-> retire.rd == exp_head.rd)
    else begin
        $display("MISMATCH time=%0t retire.rd got=%0d expected=%0d",
                 $time, $sampled(retire.rd), $sampled(exp_head.rd));
        mismatch_count++;
    end

    a_retire_value: assert property (@(posedge clk) disable iff (rst)
        checking |-> retire.value == exp_head.value)
    else begin
        $display("MISMATCH time=%0t retire.value got=%h expected=%h",
                 $time, $sampled(retire.value), $sampled(exp_head.value));
        mismatch_count++;
    end

    a_retire_we: assert property (@(posedge clk) disable iff (rst)
        checking |-> retire.we == exp_head.we)
    else begin
        $display("MISMATCH time=%0t retire.we got=%b expected=%b",
                 $time, $sampled(retire.we), $sampled(exp_head.we));
        mismatch_count++;
    end

    // ========================================================================
    // read size checks
    // ========================================================================
    // loads read above the program, in program order
    assign load_ar = arvalid && arready && (araddr >= data_base);

    always @(posedge clk) begin
        if (load_ar) begin
            loads_seen <= loads_seen + 1;
            if (loads_seen + 1 < size_q.size()) begin
                size_head <= size_q[loads_seen + 1];
            end
        end
    end

    a_load_size: assert property (@(posedge clk) disable iff (rst)
        load_ar |-> arsize == size_head)
    else begin
        $display("MISMATCH time=%0t arsize got=%0d expected=%0d",
                 $time, $sampled(arsize), $sampled(size_head));
        mismatch_count++;
    end

    a_fetch_size: assert property (@(posedge clk) disable iff (rst)
        arvalid && (araddr < data_base) |-> arsize == 3'd2)
    else begin
        $display("MISMATCH time=%0t arsize got=%0d expected=2",
                 $time, $sampled(arsize));
        mismatch_count++;
    end

    // ========================================================================
    // reset and status flags
    // ========================================================================
    a_reset_quiet: assert property (@(posedge clk)
        rst |=> !arvalid && !retire_valid && !illegal_inst && !bus_error)
    else begin
        $display("outputs not low after a reset cycle at %0t", $time);
        error_count++;
    end

    a_first_fetch: assert property (@(posedge clk)
        $fell(rst) |-> ##[1:2] (arvalid && (araddr == pc_reset)))
    else begin
        $display("no fetch from the reset pc shortly after reset, at %0t", $time);
        error_count++;
    end

    a_illegal_sticky: assert property (@(posedge clk) disable iff (rst)
        illegal_inst |=> illegal_inst)
    else begin
        $display("illegal_inst dropped after being set, at %0t", $time);
        error_count++;
    end

    a_illegal_seen: assert property (@(posedge clk) disable iff (rst)
        checking && (retire.pc == illegal_pc) |-> illegal_inst)
    else begin
        $display("illegal word retired without setting illegal_inst, at %0t", $time);
        error_count++;
    end

    a_bus_error_sticky: assert property (@(posedge clk) disable iff (rst)
        bus_error |=> bus_error)
    else begin
        $display("bus_error dropped after being set, at %0t", $time);
        error_count++;
    end

    // only the load from the error address may raise it
    a_bus_error_source: assert property (@(posedge clk) disable iff (rst)
        checking |-> bus_error == (retire.pc == err_pc))
    else begin
        $display("bus_error does not follow the error load, at %0t", $time);
        error_count++;
    end

    // ========================================================================
    // main sequence
    // ========================================================================
    initial begin
        void'($urandom(32'hed56_5ae9));
        fill_memory();
        build_program();
        run_reference();
        exp_total = exp_q.size();
        exp_head  = exp_q[0];
        size_head = size_q[0];
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        while ((retired < exp_total) && (cycles < cycle_limit)) begin
            @(posedge clk);
        end
        if (retired < exp_total) begin
            $display("timeout after %0d cycles, %0d of %0d instructions retired",
                     cycles, retired, exp_total);
            error_count++;
        end
        repeat (4) @(posedge clk);
        assert (illegal_inst) else begin
            $display("illegal_inst low at the end of the run");
            error_count++;
        end
        assert (bus_error) else begin
            $display("bus_error low at the end of the run");
            error_count++;
        end
        sva_fails = dut_i.arb_i.sva_i.fail_count;
        $display("retired %0d of %0d, mismatches %0d, errors %0d, bus check failures %0d",
                 retired, exp_total, mismatch_count, error_count, sva_fails);
        if ((mismatch_count + error_count + sva_fails) == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
core_pkg.sv
read_arbiter.sv
fetch_unit.sv
inst_decode.sv
load_execute.sv
result_writeback.sv
mini_core_top.sv
core_sva.sv
tb_top.sv
